// File: Makefile
# Verilator build and run for the trap-entry monitor
# Any variable can be overridden, for example: make test LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_trap_monitor
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
FAIL_MSG  ?= Testbench failed
PASS_MSG  ?= Testbench passed

SOURCES := $(wildcard source/*.sv) $(wildcard verif/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: source/csr_cause_decoder.sv
`timescale 1ns/1ps

module csr_cause_decoder (
  input  logic                             clk,
  input  logic                             rst_ni,
  input  logic                             csr_save_cause_i,
  input  logic                             cause_interrupt_i,
  input  logic [trap_mon_pkg::CAUSE_W-1:0] cause_code_i,
  input  trap_mon_pkg::addr_t               mepc_n_i,
  output logic                             act_valid_o,
  output trap_mon_pkg::exc_kind_e           act_kind_o,
  output trap_mon_pkg::addr_t               act_pc_o
);
  import trap_mon_pkg::*;

  logic      code_known;
  logic      save_valid;
  exc_kind_e code_kind;

  // Map the saved exception code onto a tracked kind
  always_comb begin
    code_known = 1'b1;
    code_kind  = KIND_ILLEGAL;
    case (cause_code_i)
      CAUSE_ILLEGAL_INSN:    code_kind = KIND_ILLEGAL;
      CAUSE_ECALL_MMODE:     code_kind = KIND_ECALL;
      CAUSE_BREAKPOINT:      code_kind = KIND_EBREAK;
      CAUSE_INSTR_BUS_FAULT: code_kind = KIND_INSTR_BUS_ERR;
      CAUSE_INSTR_MPU_FAULT: code_kind = KIND_INSTR_MPU_ERR;
      // Other codes are not tracked here
      default:               code_known = 1'b0;
    endcase
  end

  // Interrupt entries also save a cause but are not of interest
  assign save_valid = csr_save_cause_i && !cause_interrupt_i && code_known;

  //////////////////////////////
  // Event register
  //////////////////////////////

  always_ff @(posedge clk, negedge rst_ni) begin
    if (!rst_ni) begin
      act_valid_o <= 1'b0;
    end else begin
      act_valid_o <= save_valid;
    end
  end

  // The mepc being written is the PC that the core reports for this trap
  always_ff @(posedge clk) begin
    if (save_valid) begin
      act_kind_o <= code_kind;
      act_pc_o   <= mepc_n_i;
    end
  end

endmodule

// File: source/first_event_table.sv
`timescale 1ns/1ps

module first_event_table (
  input  logic                    clk,
  input  logic                    rst_ni,
  input  logic                    ev_valid_i,
  input  trap_mon_pkg::exc_kind_e  ev_kind_i,
  input  trap_mon_pkg::addr_t      ev_pc_i,
  output trap_mon_pkg::kind_vec_t  found_o,
  output trap_mon_pkg::addr_t      pc_table_o [trap_mon_pkg::NUM_KINDS]
);
  import trap_mon_pkg::*;

  kind_vec_t ev_hit;
  kind_vec_t found_q;
  addr_t     pc_q [NUM_KINDS];

  // One-hot of the incoming kind, empty when there is no event
  assign ev_hit = ev_valid_i ? (kind_vec_t'(1) << ev_kind_i) : '0;

  // Each slot takes the first event of its kind and then freezes
  always_ff @(posedge clk, negedge rst_ni) begin
    if (!rst_ni) begin
      found_q <= '0;
      for (int k = 0; k < NUM_KINDS; k++) begin
        pc_q[k] <= '0;
      end
    end else begin
      for (int k = 0; k < NUM_KINDS; k++) begin
        if (ev_hit[k] && !found_q[k]) begin
          found_q[k] <= 1'b1;
          pc_q[k]    <= ev_pc_i;
        end
      end
    end
  end

  assign found_o = found_q;

  // Unpacked arrays are copied slot by slot
  always_comb begin
    for (int k = 0; k < NUM_KINDS; k++) begin
      pc_table_o[k] = pc_q[k];
    end
  end

endmodule

// File: source/mepc_checker.sv
`timescale 1ns/1ps

module mepc_checker (
  input  logic                   clk,
  input  logic                   rst_ni,
  input  trap_mon_pkg::kind_vec_t exp_found_i,
  input  trap_mon_pkg::kind_vec_t act_found_i,
  input  trap_mon_pkg::addr_t     exp_pc_i [trap_mon_pkg::NUM_KINDS],
  input  trap_mon_pkg::addr_t     act_pc_i [trap_mon_pkg::NUM_KINDS],
  output trap_mon_pkg::kind_vec_t checked_o,
  output trap_mon_pkg::kind_vec_t mismatch_o
);
  import trap_mon_pkg::*;

  kind_vec_t both_found;
  kind_vec_t pc_differs;
  kind_vec_t checked_q;
  kind_vec_t mismatch_q;

  // A kind is comparable once each table holds an entry for it
  assign both_found = exp_found_i & act_found_i;

  always_comb begin
    for (int k = 0; k < NUM_KINDS; k++) begin
      pc_differs[k] = (exp_pc_i[k] != act_pc_i[k]);
    end
  end

  //////////////////////////////
  // Sticky results
  //////////////////////////////

  // The tables never change after their first entry, so the OR only
  // keeps a result that is already final
  always_ff @(posedge clk, negedge rst_ni) begin
    if (!rst_ni) begin
      checked_q  <= '0;
      mismatch_q <= '0;
    end else begin
      checked_q  <= checked_q | both_found;
      mismatch_q <= mismatch_q | (both_found & pc_differs);
    end
  end

  assign checked_o  = checked_q;
  assign mismatch_o = mismatch_q;

endmodule

// File: source/trap_mon_pkg.sv
package trap_mon_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////

  // Width of a PC or an mepc value
  localparam int unsigned ADDR_W = 32;

  // Number of exception kinds that the monitor tracks
  localparam int unsigned NUM_KINDS = 5;

  // Width of the exception code field in mcause
  localparam int unsigned CAUSE_W = 11;

  //////////////////////////////
  // Types
  //////////////////////////////

  // Tracked kinds. The enum value is also the bit index in every kind vector
  typedef enum logic [2:0] {
    KIND_ILLEGAL       = 3'd0,
    KIND_ECALL         = 3'd1,
    KIND_EBREAK        = 3'd2,
    KIND_INSTR_BUS_ERR = 3'd3,
    KIND_INSTR_MPU_ERR = 3'd4
  } exc_kind_e;

  // One bit per tracked kind
  typedef logic [NUM_KINDS-1:0] kind_vec_t;

  typedef logic [ADDR_W-1:0] addr_t;

  // Result of the MPU check on an instruction fetch
  typedef enum logic [1:0] {
    MPU_OK       = 2'd0,
    MPU_RE_FAULT = 2'd1,
    MPU_WR_FAULT = 2'd2
  } mpu_status_e;

  //////////////////////////////
  // Cause codes
  //////////////////////////////

  // Synchronous exception codes as written to mcause by the core
  localparam logic [CAUSE_W-1:0] CAUSE_INSTR_MPU_FAULT = 11'd1;
  localparam logic [CAUSE_W-1:0] CAUSE_ILLEGAL_INSN    = 11'd2;
  localparam logic [CAUSE_W-1:0] CAUSE_BREAKPOINT      = 11'd3;
  localparam logic [CAUSE_W-1:0] CAUSE_ECALL_MMODE     = 11'd11;
  localparam logic [CAUSE_W-1:0] CAUSE_INSTR_BUS_FAULT = 11'd48;

endpackage

// File: source/trap_monitor_top.sv
`timescale 1ns/1ps

module trap_monitor_top (
  input  logic                             clk,
  input  logic                             rst_ni,
  // Writeback observation
  input  logic                             wb_instr_valid_i,
  input  trap_mon_pkg::addr_t               wb_pc_i,
  input  logic                             wb_illegal_i,
  input  logic                             wb_ecall_i,
  input  logic                             wb_ebrk_i,
  input  logic                             wb_bus_err_i,
  input  trap_mon_pkg::mpu_status_e         wb_mpu_status_i,
  // Conditions that keep a writeback from trapping
  input  logic                             irq_ack_i,
  input  logic                             debug_pending_i,
  input  logic                             debug_allowed_i,
  input  logic                             exc_pc_nmi_i,
  input  logic                             debug_mode_n_i,
  // Cause save observation
  input  logic                             csr_save_cause_i,
  input  logic                             cause_interrupt_i,
  input  logic [trap_mon_pkg::CAUSE_W-1:0] cause_code_i,
  input  trap_mon_pkg::addr_t               mepc_n_i,
  // Results
  output trap_mon_pkg::kind_vec_t           checked_o,
  output trap_mon_pkg::kind_vec_t           mismatch_o
);
  import trap_mon_pkg::*;

  // Expected stream from writeback
  logic      exp_valid;
  exc_kind_e exp_kind;
  addr_t     exp_pc;

  // Actual stream from cause saves
  logic      act_valid;
  exc_kind_e act_kind;
  addr_t     act_pc;

  kind_vec_t exp_found;
  kind_vec_t act_found;
  addr_t     exp_pc_table [NUM_KINDS];
  addr_t     act_pc_table [NUM_KINDS];

  ////////////////////////////////
  // Stage 1 classification
  ////////////////////////////////

  wb_exc_classifier wb_exc_classifier_inst (
    .clk              (clk),
    .rst_ni           (rst_ni),
    .wb_instr_valid_i (wb_instr_valid_i),
    .wb_illegal_i     (wb_illegal_i),
    .wb_ecall_i       (wb_ecall_i),
    .wb_ebrk_i        (wb_ebrk_i),
    .wb_bus_err_i     (wb_bus_err_i),
    .irq_ack_i        (irq_ack_i),
    .debug_pending_i  (debug_pending_i),
    .debug_allowed_i  (debug_allowed_i),
    .exc_pc_nmi_i     (exc_pc_nmi_i),
    .debug_mode_n_i   (debug_mode_n_i),
    .wb_pc_i          (wb_pc_i),
    .wb_mpu_status_i  (wb_mpu_status_i),
    .exp_valid_o      (exp_valid),
    .exp_kind_o       (exp_kind),
    .exp_pc_o         (exp_pc)
  );

  csr_cause_decoder csr_cause_decoder_inst (
    .clk               (clk),
    .rst_ni            (rst_ni),
    .csr_save_cause_i  (csr_save_cause_i),
    .cause_interrupt_i (cause_interrupt_i),
    .cause_code_i      (cause_code_i),
    .mepc_n_i          (mepc_n_i),
    .act_valid_o       (act_valid),
    .act_kind_o        (act_kind),
    .act_pc_o          (act_pc)
  );

  ////////////////////////////////
  // Stage 2 first-event tables
  ////////////////////////////////

  first_event_table exp_table_inst (
    .clk        (clk),
    .rst_ni     (rst_ni),
    .ev_valid_i (exp_valid),
    .ev_kind_i  (exp_kind),
    .ev_pc_i    (exp_pc),
    .found_o    (exp_found),
    .pc_table_o (exp_pc_table)
  );

  first_event_table act_table_inst (
    .clk        (clk),
    .rst_ni     (rst_ni),
    .ev_valid_i (act_valid),
    .ev_kind_i  (act_kind),
    .ev_pc_i    (act_pc),
    .found_o    (act_found),
    .pc_table_o (act_pc_table)
  );

  // Stage 3 compares the two tables kind by kind
  mepc_checker mepc_checker_inst (
    .clk         (clk),
    .rst_ni      (rst_ni),
    .exp_found_i (exp_found),
    .act_found_i (act_found),
    .exp_pc_i    (exp_pc_table),
    .act_pc_i    (act_pc_table),
    .checked_o   (checked_o),
    .mismatch_o  (mismatch_o)
  );

endmodule

// File: source/wb_exc_classifier.sv
`timescale 1ns/1ps

module wb_exc_classifier (
  input  logic                     clk,
  input  logic                     rst_ni,
  input  logic                     wb_instr_valid_i,
  input  logic                     wb_illegal_i,
  input  logic                     wb_ecall_i,
  input  logic                     wb_ebrk_i,
  input  logic                     wb_bus_err_i,
  input  logic                     irq_ack_i,
  input  logic                     debug_pending_i,
  input  logic                     debug_allowed_i,
  input  logic                     exc_pc_nmi_i,
  input  logic                     debug_mode_n_i,
  input  trap_mon_pkg::addr_t       wb_pc_i,
  input  trap_mon_pkg::mpu_status_e wb_mpu_status_i,
  output logic                     exp_valid_o,
  output trap_mon_pkg::exc_kind_e   exp_kind_o,
  output trap_mon_pkg::addr_t       exp_pc_o
);
  import trap_mon_pkg::*;

  logic      suppress;
  logic      any_exc;
  logic      kind_allowed;
  logic      exc_valid;
  exc_kind_e sel_kind;

  // A writeback does not trap when an interrupt, a debug entry or an NMI wins
  assign suppress = irq_ack_i || (debug_pending_i && debug_allowed_i) || exc_pc_nmi_i;

  // Pick the single highest-priority kind present on the writeback
  // A higher kind always masks the lower ones, even if it is itself blocked later
  always_comb begin
    any_exc  = 1'b1;
    sel_kind = KIND_EBREAK;
    if (wb_mpu_status_i != MPU_OK) begin
      sel_kind = KIND_INSTR_MPU_ERR;
    end else if (wb_bus_err_i) begin
      sel_kind = KIND_INSTR_BUS_ERR;
    end else if (wb_illegal_i) begin
      sel_kind = KIND_ILLEGAL;
    end else if (wb_ecall_i) begin
      sel_kind = KIND_ECALL;
    end else if (wb_ebrk_i) begin
      sel_kind = KIND_EBREAK;
    end else begin
      any_exc = 1'b0;
    end
  end

  // Ebreak may enter debug mode instead, so only it is exempt from the debug rule
  assign kind_allowed = (sel_kind == KIND_EBREAK) || !debug_mode_n_i;

  assign exc_valid = wb_instr_valid_i && any_exc && !suppress && kind_allowed;

  //////////////////////////////
  // Event register
  //////////////////////////////

  always_ff @(posedge clk, negedge rst_ni) begin
    if (!rst_ni) begin
      exp_valid_o <= 1'b0;
    end else begin
      exp_valid_o <= exc_valid;
    end
  end

  // Kind and PC only matter while the valid is high
  always_ff @(posedge clk) begin
    if (exc_valid) begin
      exp_kind_o <= sel_kind;
      exp_pc_o   <= wb_pc_i;
    end
  end

endmodule

// File: verif/tb_trap_monitor.sv
`timescale 1ns/1ps

module tb_trap_monitor;
  import trap_mon_pkg::*;

  localparam int MAX_STEPS     = 32;
  localparam int POLL_LIMIT    = 20;
  localparam int SETTLE_CYCLES = 4;
  localparam int RESET_CYCLES  = 10;

  // How the mepc of a cause save is chosen
  localparam int MEPC_SAME  = 0;  // first writeback PC of the saved kind
  localparam int MEPC_OTHER = 1;  // that PC with one bit flipped
  localparam int MEPC_FRESH = 2;  // a new random value

  //////////////////////////////
  // DUT signals
  //////////////////////////////

  logic               clk;
  logic               rst_ni;
  logic               wb_instr_valid_i;
  addr_t              wb_pc_i;
  logic               wb_illegal_i;
  logic               wb_ecall_i;
  logic               wb_ebrk_i;
  logic               wb_bus_err_i;
  mpu_status_e        wb_mpu_status_i;
  logic               irq_ack_i;
  logic               debug_pending_i;
  logic               debug_allowed_i;
  logic               exc_pc_nmi_i;
  logic               debug_mode_n_i;
  logic               csr_save_cause_i;
  logic               cause_interrupt_i;
  logic [CAUSE_W-1:0] cause_code_i;
  addr_t              mepc_n_i;
  kind_vec_t          checked_o;
  kind_vec_t          mismatch_o;

  //////////////////////////////
  // Step table
  //////////////////////////////

  string              st_name     [MAX_STEPS];
  logic               st_wb_valid [MAX_STEPS];
  logic               st_illegal  [MAX_STEPS];
  logic               st_ecall    [MAX_STEPS];
  logic               st_ebrk     [MAX_STEPS];
  logic               st_bus_err  [MAX_STEPS];
  mpu_status_e        st_mpu      [MAX_STEPS];
  // Debug pending and debug allowed are raised together by one flag
  logic               st_irq      [MAX_STEPS];
  logic               st_dbg      [MAX_STEPS];
  logic               st_nmi      [MAX_STEPS];
  logic               st_dmode    [MAX_STEPS];
  logic               st_save     [MAX_STEPS];
  logic               st_intr     [MAX_STEPS];
  logic [CAUSE_W-1:0] st_code     [MAX_STEPS];
  int                 st_mepc_sel [MAX_STEPS];
  kind_vec_t          st_checked  [MAX_STEPS];
  kind_vec_t          st_mismatch [MAX_STEPS];
  int                 num_steps;

  // Reference model of both first-event tables
  kind_vec_t          model_exp_found;
  kind_vec_t          model_act_found;
  addr_t              model_exp_pc [NUM_KINDS];
  addr_t              model_act_pc [NUM_KINDS];

  logic [31:0]        rand_state;

  trap_monitor_top trap_monitor_top_inst (
    .clk               (clk),
    .rst_ni            (rst_ni),
    .wb_instr_valid_i  (wb_instr_valid_i),
    .wb_pc_i           (wb_pc_i),
    .wb_illegal_i      (wb_illegal_i),
    .wb_ecall_i        (wb_ecall_i),
    .wb_ebrk_i         (wb_ebrk_i),
    .wb_bus_err_i      (wb_bus_err_i),
    .wb_mpu_status_i   (wb_mpu_status_i),
    .irq_ack_i         (irq_ack_i),
    .debug_pending_i   (debug_pending_i),
    .debug_allowed_i   (debug_allowed_i),
    .exc_pc_nmi_i      (exc_pc_nmi_i),
    .debug_mode_n_i    (debug_mode_n_i),
    .csr_save_cause_i  (csr_save_cause_i),
    .cause_interrupt_i (cause_interrupt_i),
    .cause_code_i      (cause_code_i),
    .mepc_n_i          (mepc_n_i),
    .checked_o         (checked_o),
    .mismatch_o        (mismatch_o)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // PCs are word aligned like real instruction addresses
  task automatic next_pc(output addr_t pc);
    rand_state = lcg_next(rand_state);
    pc = {rand_state[31:2], 2'b00};
  endtask

  task automatic fail_run();
    $display("Testbench failed");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic check_kind_vec(input string name, input string what,
                                input kind_vec_t exp_v, input kind_vec_t act_v);
    if (act_v !== exp_v) begin
      $display("** Error %s %s: expected %b, actual %b", name, what, exp_v, act_v);
      fail_run();
    end
  endtask

  // Kind index named by a cause code, or -1 when the code is not tracked
  function automatic int code_kind(input logic [CAUSE_W-1:0] code);
    case (code)
      CAUSE_ILLEGAL_INSN:    return int'(KIND_ILLEGAL);
      CAUSE_ECALL_MMODE:     return int'(KIND_ECALL);
      CAUSE_BREAKPOINT:      return int'(KIND_EBREAK);
      CAUSE_INSTR_BUS_FAULT: return int'(KIND_INSTR_BUS_ERR);
      CAUSE_INSTR_MPU_FAULT: return int'(KIND_INSTR_MPU_ERR);
      default:               return -1;
    endcase
  endfunction

  // Kind that a writeback step should record, or -1 for none
  function automatic int wb_event_kind(input int i);
    int k;
    if (!st_wb_valid[i] || st_irq[i] || st_dbg[i] || st_nmi[i]) begin
      return -1;
    end
    if (st_mpu[i] != MPU_OK) k = int'(KIND_INSTR_MPU_ERR);
    else if (st_bus_err[i]) k = int'(KIND_INSTR_BUS_ERR);
    else if (st_illegal[i]) k = int'(KIND_ILLEGAL);
    else if (st_ecall[i]) k = int'(KIND_ECALL);
    else if (st_ebrk[i]) k = int'(KIND_EBREAK);
    else return -1;
    // In debug mode only ebreak still counts
    if (k != int'(KIND_EBREAK) && st_dmode[i]) begin
      return -1;
    end
    return k;
  endfunction

  task automatic add_step(input string name, input logic wb_v, ill, ecall, ebrk, bus,
                          input mpu_status_e mpu, input logic irq, dbg, nmi, dmode,
                          input logic save, intr, input logic [CAUSE_W-1:0] code,
                          input int mepc_sel, input kind_vec_t chk, mis);
    st_name[num_steps]     = name;
    st_wb_valid[num_steps] = wb_v;
    st_illegal[num_steps]  = ill;
    st_ecall[num_steps]    = ecall;
    st_ebrk[num_steps]     = ebrk;
    st_bus_err[num_steps]  = bus;
    st_mpu[num_steps]      = mpu;
    st_irq[num_steps]      = irq;
    st_dbg[num_steps]      = dbg;
    st_nmi[num_steps]      = nmi;
    st_dmode[num_steps]    = dmode;
    st_save[num_steps]     = save;
    st_intr[num_steps]     = intr;
    st_code[num_steps]     = code;
    st_mepc_sel[num_steps] = mepc_sel;
    st_checked[num_steps]  = chk;
    st_mismatch[num_steps] = mis;
    num_steps++;
  endtask

  // Result bits are {mpu, bus, ebreak, ecall, illegal}
  task automatic build_table();
    add_step("reset_idle", 0, 0, 0, 0, 0, MPU_OK, 0, 0, 0, 0,
             0, 0, '0, MEPC_FRESH, 5'b00000, 5'b00000);
    add_step("ill_wb_irq", 1, 1, 0, 0, 0, MPU_OK, 1, 0, 0, 0,
             0, 0, '0, MEPC_FRESH, 5'b00000, 5'b00000);
    add_step("ill_wb_novalid", 0, 1, 0, 0, 0, MPU_OK, 0, 0, 0, 0,
             0, 0, '0, MEPC_FRESH, 5'b00000, 5'b00000);
    add_step("ill_wb_dmode", 1, 1, 0, 0, 0, MPU_OK, 0, 0, 0, 1,
             0, 0, '0, MEPC_FRESH, 5'b00000, 5'b00000);
    add_step("ill_ecall_wb", 1, 1, 1, 0, 0, MPU_OK, 0, 0, 0, 0,
             0, 0, '0, MEPC_FRESH, 5'b00000, 5'b00000);
    add_step("ill_code_nosave", 0, 0, 0, 0, 0, MPU_OK, 0, 0, 0, 0,
             0, 0, CAUSE_ILLEGAL_INSN, MEPC_FRESH, 5'b00000, 5'b00000);
    add_step("unknown_code_save", 0, 0, 0, 0, 0, MPU_OK, 0, 0, 0, 0,
             1, 0, 11'd5, MEPC_FRESH, 5'b00000, 5'b00000);
    add_step("ill_save", 0, 0, 0, 0, 0, MPU_OK, 0, 0, 0, 0,
             1, 0, CAUSE_ILLEGAL_INSN, MEPC_SAME, 5'b00001, 5'b00000);
    add_step("ecall_wb_nmi", 1, 0, 1, 0, 0, MPU_OK, 0, 0, 1, 0,
             0, 0, '0, MEPC_FRESH, 5'b00001, 5'b00000);
    add_step("ecall_wb_dbg", 1, 0, 1, 0, 0, MPU_OK, 0, 1, 0, 0,
             0, 0, '0, MEPC_FRESH, 5'b00001, 5'b00000);
    add_step("ecall_wb", 1, 0, 1, 0, 0, MPU_OK, 0, 0, 0, 0,
             0, 0, '0, MEPC_FRESH, 5'b00001, 5'b00000);
    add_step("ecall_save", 0, 0, 0, 0, 0, MPU_OK, 0, 0, 0, 0,
             1, 0, CAUSE_ECALL_MMODE, MEPC_SAME, 5'b00011, 5'b00000);
    add_step("ebrk_wb_dmode", 1, 0, 0, 1, 0, MPU_OK, 0, 0, 0, 1,
             0, 0, '0, MEPC_FRESH, 5'b00011, 5'b00000);
    add_step("ebrk_save_irq", 0, 0, 0, 0, 0, MPU_OK, 0, 0, 0, 0,
             1, 1, CAUSE_BREAKPOINT, MEPC_FRESH, 5'b00011, 5'b00000);
    add_step("ebrk_save", 0, 0, 0, 0, 0, MPU_OK, 0, 0, 0, 0,
             1, 0, CAUSE_BREAKPOINT, MEPC_SAME, 5'b00111, 5'b00000);
    add_step("bus_ill_wb", 1, 1, 0, 0, 1, MPU_OK, 0, 0, 0, 0,
             0, 0, '0, MEPC_FRESH, 5'b00111, 5'b00000);
    add_step("bus_save", 0, 0, 0, 0, 0, MPU_OK, 0, 0, 0, 0,
             1, 0, CAUSE_INSTR_BUS_FAULT, MEPC_SAME, 5'b01111, 5'b00000);
    add_step("bus_save_again", 0, 0, 0, 0, 0, MPU_OK, 0, 0, 0, 0,
             1, 0, CAUSE_INSTR_BUS_FAULT, MEPC_OTHER, 5'b01111, 5'b00000);
    add_step("mpu_bus_wb", 1, 0, 0, 0, 1, MPU_RE_FAULT, 0, 0, 0, 0,
             0, 0, '0, MEPC_FRESH, 5'b01111, 5'b00000);
    add_step("mpu_save_bad", 0, 0, 0, 0, 0, MPU_OK, 0, 0, 0, 0,
             1, 0, CAUSE_INSTR_MPU_FAULT, MEPC_OTHER, 5'b11111, 5'b10000);
    add_step("ecall_save_again", 0, 0, 0, 0, 0, MPU_OK, 0, 0, 0, 0,
             1, 0, CAUSE_ECALL_MMODE, MEPC_OTHER, 5'b11111, 5'b10000);
  endtask

  task automatic drive_idle();
    wb_instr_valid_i  = 1'b0;
    wb_pc_i           = '0;
    wb_illegal_i      = 1'b0;
    wb_ecall_i        = 1'b0;
    wb_ebrk_i         = 1'b0;
    wb_bus_err_i      = 1'b0;
    wb_mpu_status_i   = MPU_OK;
    irq_ack_i         = 1'b0;
    debug_pending_i   = 1'b0;
    debug_allowed_i   = 1'b0;
    exc_pc_nmi_i      = 1'b0;
    debug_mode_n_i    = 1'b0;
    csr_save_cause_i  = 1'b0;
    cause_interrupt_i = 1'b0;
    cause_code_i      = '0;
    mepc_n_i          = '0;
  endtask

  //////////////////////////////
  // Step execution
  //////////////////////////////

  // Drives one observation for a single cycle and updates the model
  task automatic apply_step(input int i);
    addr_t pc;
    addr_t mepc;
    int    wk;
    int    ck;
    next_pc(pc);
    next_pc(mepc);
    wk = wb_event_kind(i);
    ck = code_kind(st_code[i]);
    if (ck >= 0 && st_mepc_sel[i] == MEPC_SAME) mepc = model_exp_pc[ck];
    if (ck >= 0 && st_mepc_sel[i] == MEPC_OTHER) mepc = model_exp_pc[ck] ^ 32'h10;
    @(posedge clk);
    #1;
    wb_instr_valid_i  = st_wb_valid[i];
    wb_pc_i           = pc;
    wb_illegal_i      = st_illegal[i];
    wb_ecall_i        = st_ecall[i];
    wb_ebrk_i         = st_ebrk[i];
    wb_bus_err_i      = st_bus_err[i];
    wb_mpu_status_i   = st_mpu[i];
    irq_ack_i         = st_irq[i];
    debug_pending_i   = st_dbg[i];
    debug_allowed_i   = st_dbg[i];
    exc_pc_nmi_i      = st_nmi[i];
    debug_mode_n_i    = st_dmode[i];
    csr_save_cause_i  = st_save[i];
    cause_interrupt_i = st_intr[i];
    cause_code_i      = st_code[i];
    mepc_n_i          = mepc;
    // Only the first event of each kind enters a table
    if (wk >= 0 && !model_exp_found[wk]) begin
      model_exp_found[wk] = 1'b1;
      model_exp_pc[wk]    = pc;
    end
    if (st_save[i] && !st_intr[i] && ck >= 0 && !model_act_found[ck]) begin
      model_act_found[ck] = 1'b1;
      model_act_pc[ck]    = mepc;
    end
    @(posedge clk);
    #1;
    drive_idle();
  endtask

  // Polls on the falling edge, where registered outputs are stable
  task automatic wait_for_result(input int i);
    int cnt;
    bit done;
    done = 1'b0;
    for (cnt = 0; cnt < POLL_LIMIT && !done; cnt++) begin
      @(negedge clk);
      if (checked_o === st_checked[i] && mismatch_o === st_mismatch[i]) done = 1'b1;
    end
    if (!done) begin
      $display("Result of step %s never arrived within %0d cycles", st_name[i], POLL_LIMIT);
      fail_run();
    end
  endtask

  task automatic model_results(output kind_vec_t chk, output kind_vec_t mis);
    chk = model_exp_found & model_act_found;
    mis = '0;
    for (int k = 0; k < NUM_KINDS; k++) begin
      if (chk[k] && model_exp_pc[k] != model_act_pc[k]) mis[k] = 1'b1;
    end
  endtask

  initial begin
    kind_vec_t m_chk;
    kind_vec_t m_mis;
    rand_state      = 32'h4417adea;
    num_steps       = 0;
    model_exp_found = '0;
    model_act_found = '0;
    for (int k = 0; k < NUM_KINDS; k++) begin
      model_exp_pc[k] = '0;
      model_act_pc[k] = '0;
    end
    rst_ni = 1'b0;
    drive_idle();
    build_table();
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_ni = 1'b1;
    @(negedge clk);
    check_kind_vec("reset", "checked", '0, checked_o);
    check_kind_vec("reset", "mismatch", '0, mismatch_o);
    for (int i = 0; i < num_steps; i++) begin
      apply_step(i);
      wait_for_result(i);
      // Late changes would show up here as a wrong value
      repeat (SETTLE_CYCLES) @(negedge clk);
      check_kind_vec(st_name[i], "checked", st_checked[i], checked_o);
      check_kind_vec(st_name[i], "mismatch", st_mismatch[i], mismatch_o);
      model_results(m_chk, m_mis);
      check_kind_vec(st_name[i], "model checked", st_checked[i], m_chk);
      check_kind_vec(st_name[i], "model mismatch", st_mismatch[i], m_mis);
    end
    $display("Testbench passed");
    $finish;
  end

endmodule

// File: vlog.f
source/trap_mon_pkg.sv
source/wb_exc_classifier.sv
source/csr_cause_decoder.sv
source/first_event_table.sv
source/mepc_checker.sv
source/trap_monitor_top.sv
verif/tb_trap_monitor.sv
